// ==== cubePkg.sv ====
`default_nettype none

package cubePkg;

    // 12-bit rgb sticker colour, 4 bits per channel
    typedef logic [11:0] colorT;

    localparam colorT colorYellow = 12'hff0;

    // move opcodes sent to the turning mechanism
    typedef enum logic [4:0] {
        moveR      = 5'b00000,
        moveRPrime = 5'b00001,
        moveF      = 5'b00010,
        moveFPrime = 5'b00011,
        moveU      = 5'b00100,
        moveUPrime = 5'b00101,
        // whole cube rotation about the vertical axis
        moveY      = 5'b01010,
        moveIdle   = 5'b11111
    } moveOp;

    // last-layer orientation cases seen from the front and back views
    typedef enum logic [3:0] {
        caseNone   = 4'd0,
        case1      = 4'd1,
        case2      = 4'd2,
        case3      = 4'd3,
        case4      = 4'd4,
        case5      = 4'd5,
        case6      = 4'd6,
        case7      = 4'd7,
        caseSolved = 4'd8
    } ollCase;

    // position inside an algorithm
    typedef logic [3:0] stepIdx;

    typedef enum logic [1:0] {
        stSeek  = 2'd0,
        stSolve = 2'd1,
        stDone  = 2'd2
    } solverState;

endpackage

`default_nettype wire

// ==== ollMatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module ollMatcher (
    input  wire cubePkg::colorT  f2,
    input  wire cubePkg::colorT  f4,
    input  wire cubePkg::colorT  f6,
    input  wire cubePkg::colorT  f8,
    input  wire cubePkg::colorT  f9,
    input  wire cubePkg::colorT  f10,
    input  wire cubePkg::colorT  f11,
    input  wire cubePkg::colorT  f12,
    input  wire cubePkg::colorT  b1,
    input  wire cubePkg::colorT  b3,
    input  wire cubePkg::colorT  b5,
    input  wire cubePkg::colorT  b7,
    output cubePkg::ollCase      matchedCase
);
    import cubePkg::*;

    logic yF2;
    logic yF4;
    logic yF6;
    logic yF8;
    logic yF9;
    logic yF10;
    logic yF11;
    logic yF12;
    logic yB1;
    logic yB3;
    logic yB5;
    logic yB7;

    assign yF2  = (f2  == colorYellow);
    assign yF4  = (f4  == colorYellow);
    assign yF6  = (f6  == colorYellow);
    assign yF8  = (f8  == colorYellow);
    assign yF9  = (f9  == colorYellow);
    assign yF10 = (f10 == colorYellow);
    assign yF11 = (f11 == colorYellow);
    assign yF12 = (f12 == colorYellow);
    assign yB1  = (b1  == colorYellow);
    assign yB3  = (b3  == colorYellow);
    assign yB5  = (b5  == colorYellow);
    assign yB7  = (b7  == colorYellow);

    // first satisfied rule wins, solved face is checked last
    always_comb begin
        if (yF12 && yF2 && yF6 && yB7) begin
            matchedCase = case1;
        end else if (yF9 && yF4 && yF8 && yB5) begin
            matchedCase = case2;
        end else if (yF12 && yF10 && yF2 && yF8) begin
            matchedCase = case3;
        end else if (yF2 && yF10 && yF11 && yB5) begin
            matchedCase = case4;
        end else if (yF10 && yF11 && yB1 && yB3) begin
            matchedCase = case5;
        end else if (yF2 && yF4 && yB5 && yB7) begin
            matchedCase = case6;
        end else if (yF4 && yB1 && yB3 && yB7) begin
            matchedCase = case7;
        end else if (yF9 && yF10 && yF11 && yF12) begin
            matchedCase = caseSolved;
        end else begin
            matchedCase = caseNone;
        end
    end

endmodule

`default_nettype wire

// ==== movePacer.sv ====
`timescale 1ns/1ps
`default_nettype none

module movePacer #(
    parameter int moveInterval = 2 ** 25
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  pacerRun,
    output logic tick
);

    // an interval of one still needs a one-bit counter
    localparam int cntW = (moveInterval > 1) ? $clog2(moveInterval) : 1;
    localparam logic [cntW-1:0] lastCount = cntW'(moveInterval - 1);

    logic [cntW-1:0] count;

    assign tick = pacerRun && (count == lastCount);

    // counts only enabled cycles, holds otherwise
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (pacerRun) begin
            if (tick) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== algorithmTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module algorithmTable (
    input  wire cubePkg::ollCase  solveCase,
    input  wire cubePkg::stepIdx  step,
    output cubePkg::moveOp        move,
    output logic                  lastStep
);
    import cubePkg::*;

    stepIdx lastIdx;

    always_comb begin
        move    = moveIdle;
        lastIdx = '0;
        case (solveCase)
            case1: begin
                // R' U' R U' R' U U R
                lastIdx = 4'd7;
                case (step)
                    4'd0: move = moveRPrime;
                    4'd1: move = moveUPrime;
                    4'd2: move = moveR;
                    4'd3: move = moveUPrime;
                    4'd4: move = moveRPrime;
                    4'd5: move = moveU;
                    4'd6: move = moveU;
                    4'd7: move = moveR;
                    default: move = moveIdle;
                endcase
            end
            case2: begin
                lastIdx = 4'd7;
                case (step)
                    4'd0: move = moveR;
                    4'd1: move = moveU;
                    4'd2: move = moveRPrime;
                    4'd3: move = moveU;
                    4'd4: move = moveR;
                    4'd5: move = moveUPrime;
                    4'd6: move = moveUPrime;
                    4'd7: move = moveRPrime;
                    default: move = moveIdle;
                endcase
            end
            case3: begin
                lastIdx = 4'd7;
                case (step)
                    4'd0: move = moveF;
                    4'd1: move = moveRPrime;
                    4'd2: move = moveFPrime;
                    4'd3: move = moveR;
                    4'd4: move = moveU;
                    4'd5: move = moveR;
                    4'd6: move = moveUPrime;
                    4'd7: move = moveRPrime;
                    default: move = moveIdle;
                endcase
            end
            case4: begin
                lastIdx = 4'd7;
                case (step)
                    4'd0: move = moveR;
                    4'd1: move = moveU;
                    4'd2: move = moveRPrime;
                    4'd3: move = moveUPrime;
                    4'd4: move = moveRPrime;
                    4'd5: move = moveF;
                    4'd6: move = moveR;
                    4'd7: move = moveFPrime;
                    default: move = moveIdle;
                endcase
            end
            case5: begin
                // shortest one, six turns
                lastIdx = 4'd5;
                case (step)
                    4'd0: move = moveF;
                    4'd1: move = moveR;
                    4'd2: move = moveU;
                    4'd3: move = moveRPrime;
                    4'd4: move = moveUPrime;
                    4'd5: move = moveFPrime;
                    default: move = moveIdle;
                endcase
            end
            case6: begin
                // double turns are issued as two quarter turns
                lastIdx = 4'd8;
                case (step)
                    4'd0: move = moveR;
                    4'd1: move = moveR;
                    4'd2: move = moveU;
                    4'd3: move = moveU;
                    4'd4: move = moveRPrime;
                    4'd5: move = moveU;
                    4'd6: move = moveU;
                    4'd7: move = moveRPrime;
                    4'd8: move = moveRPrime;
                    default: move = moveIdle;
                endcase
            end
            case7: begin
                lastIdx = 4'd9;
                case (step)
                    4'd0: move = moveF;
                    4'd1: move = moveR;
                    4'd2: move = moveU;
                    4'd3: move = moveRPrime;
                    4'd4: move = moveUPrime;
                    4'd5: move = moveR;
                    4'd6: move = moveU;
                    4'd7: move = moveRPrime;
                    4'd8: move = moveUPrime;
                    4'd9: move = moveFPrime;
                    default: move = moveIdle;
                endcase
            end
            default: begin
                move    = moveIdle;
                lastIdx = '0;
            end
        endcase
    end

    assign lastStep = (step == lastIdx);

endmodule

`default_nettype wire

// ==== solveSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module solveSequencer (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   ready,
    input  wire cubePkg::ollCase  matchedCase,
    input  wire                   tick,
    output logic                  pacerRun,
    output cubePkg::moveOp        move,
    output logic                  moveStrobe,
    output logic                  topFaceDone
);
    import cubePkg::*;

    solverState state;
    ollCase     heldCase;
    stepIdx     step;
    moveOp      tableMove;
    logic       lastStep;

    algorithmTable table0 (
        .solveCase (heldCase),
        .step      (step),
        .move      (tableMove),
        .lastStep  (lastStep)
    );

    // pacer runs while solving, or while searching with nothing recognised
    assign pacerRun = ready && ((state == stSolve) ||
                                ((state == stSeek) && (matchedCase == caseNone)));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= stSeek;
            heldCase <= caseNone;
            step     <= '0;
        end else if (ready) begin
            case (state)
                stSeek: begin
                    if (matchedCase == caseSolved) begin
                        state <= stDone;
                    end else if (matchedCase != caseNone) begin
                        // latch the case, the stickers may change while turning
                        heldCase <= matchedCase;
                        step     <= '0;
                        state    <= stSolve;
                    end
                end
                stSolve: begin
                    if (tick) begin
                        if (lastStep) begin
                            state <= stDone;
                        end else begin
                            step <= step + 4'd1;
                        end
                    end
                end
                stDone: begin
                    // stays here until reset
                    state <= stDone;
                end
                default: begin
                    state <= stSeek;
                end
            endcase
        end
    end

    // tick already implies ready, so moves drop out while ready is low
    always_comb begin
        move        = moveIdle;
        moveStrobe  = 1'b0;
        topFaceDone = 1'b0;
        case (state)
            stSeek: begin
                if (tick) begin
                    move       = moveY;
                    moveStrobe = 1'b1;
                end
            end
            stSolve: begin
                if (tick) begin
                    move       = tableMove;
                    moveStrobe = 1'b1;
                end
            end
            stDone: begin
                topFaceDone = ready;
            end
            default: begin
                move = moveIdle;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== topFaceSolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module topFaceSolver #(
    parameter int moveInterval = 2 ** 25
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  ready,
    input  wire cubePkg::colorT  f2,
    input  wire cubePkg::colorT  f4,
    input  wire cubePkg::colorT  f6,
    input  wire cubePkg::colorT  f8,
    input  wire cubePkg::colorT  f9,
    input  wire cubePkg::colorT  f10,
    input  wire cubePkg::colorT  f11,
    input  wire cubePkg::colorT  f12,
    input  wire cubePkg::colorT  b1,
    input  wire cubePkg::colorT  b3,
    input  wire cubePkg::colorT  b5,
    input  wire cubePkg::colorT  b7,
    output cubePkg::moveOp       move,
    output logic                 moveStrobe,
    output logic                 topFaceDone
);
    import cubePkg::*;

    ollCase matchedCase;
    logic   pacerRun;
    logic   tick;

    ollMatcher matcher (
        .f2          (f2),
        .f4          (f4),
        .f6          (f6),
        .f8          (f8),
        .f9          (f9),
        .f10         (f10),
        .f11         (f11),
        .f12         (f12),
        .b1          (b1),
        .b3          (b3),
        .b5          (b5),
        .b7          (b7),
        .matchedCase (matchedCase)
    );

    movePacer #(
        .moveInterval (moveInterval)
    ) pacer (
        .clk      (clk),
        .rst      (rst),
        .pacerRun (pacerRun),
        .tick     (tick)
    );

    solveSequencer sequencer (
        .clk         (clk),
        .rst         (rst),
        .ready       (ready),
        .matchedCase (matchedCase),
        .tick        (tick),
        .pacerRun    (pacerRun),
        .move        (move),
        .moveStrobe  (moveStrobe),
        .topFaceDone (topFaceDone)
    );

endmodule

`default_nettype wire

// ==== topFaceSolverTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module topFaceSolverTb;
    import cubePkg::*;

    localparam int clkPeriod = 4;
    localparam int interval = 8;
    localparam int testCount = 10;
    // per test up to three search turns and ten moves stretched by ready gaps
    localparam int watchdogNs = testCount * (13 * interval * 4 + 16) * clkPeriod + 400;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic ready = 1'b0;
    colorT noise [12] = '{default: 12'h000};
    // mask bits from bit 0 upward are f2 f4 f6 f8 f9 f10 f11 f12 b1 b3 b5 b7
    logic [11:0] shownMask = '0;
    logic [11:0] startMask = '0;
    logic [11:0] switchMask = '0;
    moveOp move;
    logic moveStrobe;
    logic topFaceDone;

    logic [11:0] ruleMask [1:8];
    string algText [1:7];
    moveOp expMove [32];
    int expGap [32];
    int expCount = 0;
    int doneGap = 0;
    int switchAt = 0;
    int idx = 0;
    int gap = 0;
    logic doneSeen = 1'b0;
    int readyMode = 0;
    int unsigned readySeed = 48148;
    int unsigned colorSeed = 48148;
    int errCount = 0;

    topFaceSolver #(.moveInterval(interval)) dut (
        .clk(clk), .rst(rst), .ready(ready),
        .f2(shownMask[0] ? colorYellow : noise[0]),
        .f4(shownMask[1] ? colorYellow : noise[1]),
        .f6(shownMask[2] ? colorYellow : noise[2]),
        .f8(shownMask[3] ? colorYellow : noise[3]),
        .f9(shownMask[4] ? colorYellow : noise[4]),
        .f10(shownMask[5] ? colorYellow : noise[5]),
        .f11(shownMask[6] ? colorYellow : noise[6]),
        .f12(shownMask[7] ? colorYellow : noise[7]),
        .b1(shownMask[8] ? colorYellow : noise[8]),
        .b3(shownMask[9] ? colorYellow : noise[9]),
        .b5(shownMask[10] ? colorYellow : noise[10]),
        .b7(shownMask[11] ? colorYellow : noise[11]),
        .move(move), .moveStrobe(moveStrobe), .topFaceDone(topFaceDone)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic int unsigned lcgStep(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int firstRule(input logic [11:0] mask);
        int r;
        int found;
        found = 0;
        for (r = 8; r >= 1; r--) begin
            if ((mask & ruleMask[r]) == ruleMask[r]) found = r;
        end
        return found;
    endfunction

    function automatic moveOp turnOf(input byte letter, input bit prime);
        moveOp m;
        case (letter)
            "R": m = moveR;
            "F": m = moveF;
            default: m = moveU;
        endcase
        if (prime) m = moveOp'(m + 5'd1);
        return m;
    endfunction

    // ready drops at random only in gap mode
    always @(posedge clk) begin
        if (readyMode == 2) begin
            readySeed = lcgStep(readySeed);
            ready <= (readySeed[29:28] != 2'b00);
        end else begin
            ready <= (readyMode == 1);
        end
    end

    // strobe bookkeeping and the sticker change after the last search turn
    always @(posedge clk) begin
        if (rst) begin
            idx <= 0;
            gap <= 0;
            doneSeen <= 1'b0;
            shownMask <= startMask;
        end else begin
            if (moveStrobe) begin
                idx <= idx + 1;
                gap <= 0;
                if (idx + 1 == switchAt) shownMask <= switchMask;
            end else if (ready) begin
                gap <= gap + 1;
            end
            if (topFaceDone) doneSeen <= 1'b1;
        end
    end

    idleOutputs: assert property (@(posedge clk)
        (rst || !ready) |-> (!moveStrobe && !topFaceDone && move == moveIdle))
        else begin
            errCount++;
            $display("ERR %0t: outputs active in reset or while ready is low", $time);
        end

    noExtraMove: assert property (@(posedge clk) disable iff (rst)
        moveStrobe |-> idx < expCount)
        else begin
            errCount++;
            $display("ERR %0t: unexpected strobe, move %0d", $time, $sampled(move));
        end

    moveOrder: assert property (@(posedge clk) disable iff (rst)
        (moveStrobe && idx < expCount) |-> move == expMove[idx])
        else begin
            errCount++;
            $display("ERR %0t: move %0d is %0d, expected %0d", $time, $sampled(idx),
                     $sampled(move), expMove[$sampled(idx)]);
        end

    moveSpacing: assert property (@(posedge clk) disable iff (rst)
        (moveStrobe && idx < expCount) |-> gap + 1 == expGap[idx])
        else begin
            errCount++;
            $display("ERR %0t: move %0d after %0d ready cycles, expected %0d",
                     $time, $sampled(idx), $sampled(gap) + 1, expGap[$sampled(idx)]);
        end

    doneTiming: assert property (@(posedge clk) disable iff (rst)
        (topFaceDone && !doneSeen) |-> (idx == expCount && gap == doneGap))
        else begin
            errCount++;
            $display("ERR %0t: done after %0d of %0d moves, gap %0d",
                     $time, $sampled(idx), expCount, $sampled(gap));
        end

    task automatic runTest(input logic [11:0] first, input logic [11:0] later,
                           input int yTurns, input bit gaps);
        int c;
        int k;
        int n;
        @(posedge clk);
        rst <= 1'b1;
        readyMode <= 0;
        @(posedge clk);
        for (k = 0; k < 12; k++) begin
            colorSeed = lcgStep(colorSeed);
            noise[k] <= (colorSeed[27:16] == colorYellow) ? 12'h00f : colorSeed[27:16];
        end
        startMask <= first;
        switchMask <= later;
        switchAt <= 0;
        expCount = 0;
        c = firstRule(first);
        if (c == 0) begin
            for (k = 0; k < yTurns; k++) begin
                expMove[expCount] = moveY;
                expGap[expCount] = interval;
                expCount++;
            end
            switchAt <= yTurns;
            c = firstRule(later);
        end
        n = expCount;
        if (c >= 1 && c <= 7) begin
            for (k = 0; k < algText[c].len(); k++) begin
                if (algText[c][k] != " " && algText[c][k] != "'") begin
                    expMove[expCount] = turnOf(algText[c][k],
                        k + 1 < algText[c].len() && algText[c][k + 1] == "'");
                    // recognition takes one ready cycle before the first move
                    expGap[expCount] = (expCount == n) ? interval + 1 : interval;
                    expCount++;
                end
            end
        end
        doneGap = (c == 8) ? 1 : 0;
        @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        readyMode <= gaps ? 2 : 1;
        while (!doneSeen) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    initial begin
        int order [7];
        int k;
        int j;
        int t;
        ruleMask[1] = 12'h885;
        ruleMask[2] = 12'h41a;
        ruleMask[3] = 12'h0a9;
        ruleMask[4] = 12'h461;
        ruleMask[5] = 12'h360;
        ruleMask[6] = 12'hc03;
        ruleMask[7] = 12'hb02;
        ruleMask[8] = 12'h0f0;
        algText[1] = "R' U' R U' R' U U R";
        algText[2] = "R U R' U R U' U' R'";
        algText[3] = "F R' F' R U R U' R'";
        algText[4] = "R U R' U' R' F R F'";
        algText[5] = "F R U R' U' F'";
        algText[6] = "R R U U R' U U R' R'";
        algText[7] = "F R U R' U' R U R' U' F'";
        for (k = 0; k < 7; k++) order[k] = k + 1;
        for (k = 6; k > 0; k--) begin
            colorSeed = lcgStep(colorSeed);
            j = int'(colorSeed[23:16]) % (k + 1);
            t = order[k];
            order[k] = order[j];
            order[j] = t;
        end
        for (k = 0; k < 7; k++) runTest(ruleMask[order[k]], '0, 0, k[0]);
        // nothing visible until three y turns have been made
        colorSeed = lcgStep(colorSeed);
        j = int'(colorSeed[23:16]) % 12;
        t = 1 + int'(colorSeed[15:8]) % 7;
        runTest(12'h1 << j, ruleMask[t], 3, 1'b0);
        runTest(ruleMask[8], '0, 0, 1'b0);
        // two rules at once
        colorSeed = lcgStep(colorSeed);
        j = 1 + int'(colorSeed[23:16]) % 6;
        t = j + 1 + int'(colorSeed[15:8]) % (7 - j);
        runTest(ruleMask[j] | ruleMask[t], '0, 0, 1'b1);
        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("timeout: the run did not finish within %0d ns", watchdogNs);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
cubePkg.sv
ollMatcher.sv
movePacer.sv
algorithmTable.sv
solveSequencer.sv
topFaceSolver.sv
topFaceSolverTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, a fail line in the log fails the run
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module topFaceSolverTb -f project.f -o topFaceSolverSim \
    && ./obj_dir/topFaceSolverSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
